// File: logic/mdecPkg.sv
`default_nettype none

package mdecPkg;

	// ----------------------------------------
	// Field widths and stream codes
	// ----------------------------------------
	localparam int LEVEL_W = 10;
	localparam int COEF_W = 12;
	localparam int COS_W = 16;
	// End of block marker
	localparam logic [15:0] EOB_CODE = 16'hFE00;

	// Zigzag position to linear index (row * 8 + col)
	localparam logic [0:63][5:0] zigzagLut = {
		6'd0,  6'd1,  6'd8,  6'd16, 6'd9,  6'd2,  6'd3,  6'd10,
		6'd17, 6'd24, 6'd32, 6'd25, 6'd18, 6'd11, 6'd4,  6'd5,
		6'd12, 6'd19, 6'd26, 6'd33, 6'd40, 6'd48, 6'd41, 6'd34,
		6'd27, 6'd20, 6'd13, 6'd6,  6'd7,  6'd14, 6'd21, 6'd28,
		6'd35, 6'd42, 6'd49, 6'd56, 6'd57, 6'd50, 6'd43, 6'd36,
		6'd29, 6'd22, 6'd15, 6'd23, 6'd30, 6'd37, 6'd44, 6'd51,
		6'd58, 6'd59, 6'd52, 6'd45, 6'd38, 6'd31, 6'd39, 6'd46,
		6'd53, 6'd60, 6'd61, 6'd54, 6'd47, 6'd55, 6'd62, 6'd63
	};

	// ----------------------------------------
	// Structs between blocks
	// ----------------------------------------
	// Table write strobe, index is zigzag pos or freq*8+pos
	typedef struct packed {
		logic        quantWe;
		logic        cosWe;
		logic [5:0]  index;
		logic [15:0] data;
	} cfgWrite_t;

	typedef struct packed {
		logic                      valid;
		logic signed [LEVEL_W-1:0] level;
		logic [5:0]                scale;
		logic                      isDc;
		logic [5:0]                zagPos;
		logic [5:0]                linIdx;
		logic                      last;
	} rleCoef_t;

	typedef struct packed {
		logic                     valid;
		logic [5:0]               index;
		logic signed [COEF_W-1:0] value;
		logic                     last;
	} coefWrite_t;

	typedef struct packed {
		logic       valid;
		logic [5:0] addr;
		logic [7:0] value;
	} pixel_t;

	typedef enum logic [1:0] {RLE_DC, RLE_AC, RLE_WAIT} rleState_e;
	typedef enum logic [1:0] {IDCT_LOAD, IDCT_ROW, IDCT_COL, IDCT_OUT} idctState_e;

endpackage

`default_nettype wire

// File: logic/apbConfig.sv
`timescale 1ns/1ps
`default_nettype none

module apbConfig import mdecPkg::*; #(
	parameter int ADDR_W = 12
) (
	input  wire              clk,
	input  wire              i_rstN,
	// APB slave
	input  wire              i_psel,
	input  wire              i_penable,
	input  wire              i_pwrite,
	input  wire [ADDR_W-1:0] i_paddr,
	input  wire [31:0]       i_pwdata,
	output logic [31:0]      o_prdata,
	output logic             o_pready,
	output logic             o_pslverr,
	// Core side
	input  wire              i_busy,
	output cfgWrite_t        o_cfg,
	output logic             o_signedOut
);

	logic access;
	logic isCtrl;
	logic isStatus;
	logic isQuant;
	logic isCos;
	logic mapped;

	// ----------------------------------------
	// Address decode
	// ----------------------------------------
	assign access   = i_psel && i_penable;
	assign isCtrl   = (i_paddr == ADDR_W'('h000));
	assign isStatus = (i_paddr == ADDR_W'('h004));
	// Table windows, word aligned only
	assign isQuant  = (i_paddr[ADDR_W-1:8] == (ADDR_W-8)'(1)) && (i_paddr[1:0] == 2'b00);
	assign isCos    = (i_paddr[ADDR_W-1:8] == (ADDR_W-8)'(2)) && (i_paddr[1:0] == 2'b00);
	assign mapped   = isCtrl || isStatus || isQuant || isCos;

	// No wait states
	assign o_pready  = 1'b1;
	assign o_pslverr = access && !mapped;

	// Control and status read back, tables read as zero
	always_comb
	begin
		o_prdata = '0;
		if (access && !i_pwrite)
		begin
			if (isCtrl)
				o_prdata[0] = o_signedOut;
			else if (isStatus)
				o_prdata[0] = i_busy;
		end
	end

	// Control register and strobes
	always_ff @(posedge clk)
	begin
		if (!i_rstN)
		begin
			o_signedOut   <= 1'b0;
			o_cfg.quantWe <= 1'b0;
			o_cfg.cosWe   <= 1'b0;
		end
		else
		begin
			if (access && i_pwrite && isCtrl)
				o_signedOut <= i_pwdata[0];
			// One cycle strobe per table write
			o_cfg.quantWe <= access && i_pwrite && isQuant;
			o_cfg.cosWe   <= access && i_pwrite && isCos;
		end
	end

	// Index and data follow the strobe
	always_ff @(posedge clk)
	begin
		o_cfg.index <= i_paddr[7:2];
		o_cfg.data  <= i_pwdata[15:0];
	end

endmodule

`default_nettype wire

// File: logic/rleDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module rleDecoder import mdecPkg::*; (
	input  wire         clk,
	input  wire         i_rstN,
	// Halfword stream
	input  wire         i_dataValid,
	input  wire [15:0]  i_data,
	output logic        o_dataReady,
	// IDCT holding a block
	input  wire         i_idctBusy,
	output rleCoef_t    o_coef
);

	rleState_e  state;
	logic       accept;
	logic [5:0] scale;
	logic [5:0] pos;
	logic [6:0] nextPos;
	logic       isEob;

	// ----------------------------------------
	// Handshake
	// ----------------------------------------
	// Stall while IDCT busy or block not yet taken
	assign o_dataReady = (state != RLE_WAIT) && !i_idctBusy;
	assign accept      = i_dataValid && o_dataReady;
	assign isEob       = (i_data == EOB_CODE);
	// Skip run zeros, then step onto the coef
	assign nextPos     = {1'b0, pos} + 7'(i_data[15:10]) + 7'd1;

	// Block state
	always_ff @(posedge clk)
	begin
		if (!i_rstN)
		begin
			state <= RLE_DC;
			pos   <= '0;
		end
		else
		begin
			case (state)
				RLE_DC:
				begin
					if (accept)
					begin
						state <= RLE_AC;
						pos   <= '0;
					end
				end
				RLE_AC:
				begin
					if (accept)
					begin
						pos <= nextPos[5:0];
						// Explicit EOB or run landing on/after 63
						if (isEob || (nextPos >= 7'd63))
							state <= RLE_WAIT;
					end
				end
				default:
				begin
					// Wait for IDCT to take the block
					if (i_idctBusy)
						state <= RLE_DC;
				end
			endcase
		end
	end

	// Scale held for the AC words
	always_ff @(posedge clk)
	begin
		if ((state == RLE_DC) && accept)
			scale <= i_data[15:10];
	end

	// ----------------------------------------
	// Coefficient output
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!i_rstN)
		begin
			o_coef.valid <= 1'b0;
			o_coef.last  <= 1'b0;
		end
		else if (accept && (state == RLE_DC))
		begin
			o_coef.valid <= 1'b1;
			o_coef.last  <= 1'b0;
		end
		else if (accept)
		begin
			// EOB carries last without a write
			o_coef.valid <= !isEob && (nextPos <= 7'd63);
			o_coef.last  <= isEob || (nextPos >= 7'd63);
		end
		else
		begin
			o_coef.valid <= 1'b0;
			o_coef.last  <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		o_coef.level  <= i_data[LEVEL_W-1:0];
		o_coef.isDc   <= (state == RLE_DC);
		o_coef.scale  <= (state == RLE_DC) ? i_data[15:10] : scale;
		o_coef.zagPos <= (state == RLE_DC) ? 6'd0 : nextPos[5:0];
		o_coef.linIdx <= (state == RLE_DC) ? 6'd0 : zigzagLut[nextPos[5:0]];
	end

endmodule

`default_nettype wire

// File: logic/dequantizer.sv
`timescale 1ns/1ps
`default_nettype none

module dequantizer import mdecPkg::*; (
	input  wire         clk,
	input  wire         i_rstN,
	input  rleCoef_t    i_coef,
	input  cfgWrite_t   i_cfg,
	output coefWrite_t  o_coef
);

	// Level times 8-bit quant, then times 6-bit scale
	localparam int PROD_W = LEVEL_W + 9;
	localparam int SCALED_W = PROD_W + 7;
	localparam int SAT_MAX = (1 << (COEF_W - 1)) - 1;

	logic [7:0]                 quantTbl [64];
	logic signed [PROD_W-1:0]   prodS1;
	logic [5:0]                 scaleS1;
	logic                       isDcS1;
	logic [5:0]                 idxS1;
	logic                       validS1;
	logic                       lastS1;
	logic signed [SCALED_W-1:0] scaled;
	logic signed [SCALED_W-1:0] shifted;
	logic signed [COEF_W-1:0]   satVal;

	// Quant table, zigzag order
	always_ff @(posedge clk)
	begin
		if (!i_rstN)
		begin
			for (int i = 0; i < 64; i++)
				quantTbl[i] <= '0;
		end
		else if (i_cfg.quantWe)
		begin
			quantTbl[i_cfg.index] <= i_cfg.data[7:0];
		end
	end

	// ----------------------------------------
	// Stage 1, level times quant
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!i_rstN)
		begin
			validS1 <= 1'b0;
			lastS1  <= 1'b0;
		end
		else
		begin
			validS1 <= i_coef.valid;
			lastS1  <= i_coef.last;
		end
	end

	// DC sits at zigzag 0, so one lookup covers both
	always_ff @(posedge clk)
	begin
		prodS1  <= $signed(i_coef.level) * $signed({1'b0, quantTbl[i_coef.zagPos]});
		scaleS1 <= i_coef.scale;
		isDcS1  <= i_coef.isDc;
		idxS1   <= i_coef.linIdx;
	end

	// ----------------------------------------
	// Stage 2, scale, shift, saturate
	// ----------------------------------------
	always_comb
	begin
		scaled = prodS1 * $signed({1'b0, scaleS1});
		// DC skips scale and shift
		if (isDcS1)
			shifted = SCALED_W'(prodS1);
		else
			shifted = scaled >>> 3;
		if (shifted > SAT_MAX)
			satVal = COEF_W'(SAT_MAX);
		else if (shifted < -SAT_MAX)
			satVal = COEF_W'(-SAT_MAX);
		else
			satVal = shifted[COEF_W-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (!i_rstN)
		begin
			o_coef.valid <= 1'b0;
			o_coef.last  <= 1'b0;
		end
		else
		begin
			o_coef.valid <= validS1;
			o_coef.last  <= lastS1;
		end
	end

	always_ff @(posedge clk)
	begin
		o_coef.index <= idxS1;
		o_coef.value <= satVal;
	end

endmodule

`default_nettype wire

// File: logic/idctCore.sv
`timescale 1ns/1ps
`default_nettype none

module idctCore import mdecPkg::*; (
	input  wire         clk,
	input  wire         i_rstN,
	input  coefWrite_t  i_coef,
	input  cfgWrite_t   i_cfg,
	input  wire         i_signedOut,
	output logic        o_busy,
	output pixel_t      o_pixel
);

	// Row results fit 17 bits signed, one spare
	localparam int TMP_W = 18;
	localparam int PROD_W = TMP_W + COS_W;
	localparam int ACC_W = PROD_W + 6;

	idctState_e                 state;
	logic [5:0]                 elem;
	logic [2:0]                 tap;
	logic                       lastTap;
	logic                       clearBuf;
	logic signed [COEF_W-1:0]   coefBuf [64];
	logic signed [TMP_W-1:0]    tmpBuf [64];
	logic signed [7:0]          pixBuf [64];
	logic signed [COS_W-1:0]    cosTbl [64];
	logic signed [TMP_W-1:0]    mulA;
	logic [5:0]                 cosIdx;
	logic signed [PROD_W-1:0]   prod;
	logic signed [ACC_W-1:0]    acc;
	logic signed [ACC_W-1:0]    accNext;
	logic signed [ACC_W-1:0]    accShift;
	logic signed [7:0]          clamped;

	assign o_busy   = (state != IDCT_LOAD);
	assign lastTap  = (tap == 3'd7);
	// Row pass done, coefs no longer needed
	assign clearBuf = (state == IDCT_ROW) && lastTap && (elem == 6'd63);

	// ----------------------------------------
	// Sequencer
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!i_rstN)
		begin
			state <= IDCT_LOAD;
			elem  <= '0;
			tap   <= '0;
		end
		else
		begin
			case (state)
				IDCT_LOAD:
				begin
					if (i_coef.last)
						state <= IDCT_ROW;
				end
				IDCT_ROW, IDCT_COL:
				begin
					// 8 MACs per output, counters wrap at pass end
					tap <= tap + 3'd1;
					if (lastTap)
					begin
						elem <= elem + 6'd1;
						if (elem == 6'd63)
							state <= (state == IDCT_ROW) ? IDCT_COL : IDCT_OUT;
					end
				end
				default:
				begin
					elem <= elem + 6'd1;
					if (elem == 6'd63)
						state <= IDCT_LOAD;
				end
			endcase
		end
	end

	// Coef buffer, zero for skipped positions
	always_ff @(posedge clk)
	begin
		if (!i_rstN || clearBuf)
		begin
			for (int i = 0; i < 64; i++)
				coefBuf[i] <= '0;
		end
		else if ((state == IDCT_LOAD) && i_coef.valid)
		begin
			coefBuf[i_coef.index] <= i_coef.value;
		end
	end

	// Cosine table, freq * 8 + pos
	always_ff @(posedge clk)
	begin
		if (!i_rstN)
		begin
			for (int i = 0; i < 64; i++)
				cosTbl[i] <= '0;
		end
		else if (i_cfg.cosWe)
		begin
			cosTbl[i_cfg.index] <= i_cfg.data;
		end
	end

	// ----------------------------------------
	// Shared MAC
	// ----------------------------------------
	always_comb
	begin
		// Row: F(u,v) with cos[v,x], col: tmp(u,x) with cos[u,y]
		if (state == IDCT_COL)
		begin
			mulA   = tmpBuf[{tap, elem[2:0]}];
			cosIdx = {tap, elem[5:3]};
		end
		else
		begin
			mulA   = coefBuf[{elem[5:3], tap}];
			cosIdx = {tap, elem[2:0]};
		end
		prod     = mulA * cosTbl[cosIdx];
		accNext  = ((tap == 3'd0) ? ACC_W'(0) : acc) + ACC_W'(prod);
		// Q1.14 back to integer
		accShift = accNext >>> 14;
		if (accShift > 127)
			clamped = 8'sd127;
		else if (accShift < -128)
			clamped = -8'sd128;
		else
			clamped = accShift[7:0];
	end

	always_ff @(posedge clk)
	begin
		if ((state == IDCT_ROW) || (state == IDCT_COL))
			acc <= accNext;
		if ((state == IDCT_ROW) && lastTap)
			tmpBuf[elem] <= accShift[TMP_W-1:0];
		if ((state == IDCT_COL) && lastTap)
			pixBuf[elem] <= clamped;
	end

	// Raster order out, +128 is an MSB flip
	always_comb
	begin
		o_pixel.valid = (state == IDCT_OUT);
		o_pixel.addr  = elem;
		o_pixel.value = {pixBuf[elem][7] ^ !i_signedOut, pixBuf[elem][6:0]};
	end

endmodule

`default_nettype wire

// File: logic/mdecCore.sv
`timescale 1ns/1ps
`default_nettype none

module mdecCore import mdecPkg::*; #(
	parameter int ADDR_W = 12
) (
	input  wire              clk,
	input  wire              i_rstN,
	// APB setup port
	input  wire              i_psel,
	input  wire              i_penable,
	input  wire              i_pwrite,
	input  wire [ADDR_W-1:0] i_paddr,
	input  wire [31:0]       i_pwdata,
	output logic [31:0]      o_prdata,
	output logic             o_pready,
	output logic             o_pslverr,
	// RLE stream
	input  wire              i_dataValid,
	input  wire [15:0]       i_data,
	output logic             o_dataReady,
	// Block and pixel output
	output logic             o_busy,
	output pixel_t           o_pixel
);

	cfgWrite_t  cfg;
	rleCoef_t   rleCoef;
	coefWrite_t coefWr;
	logic       signedOut;
	logic       idctBusy;

	assign o_busy = idctBusy;

	// ----------------------------------------
	// Setup registers and table strobes
	// ----------------------------------------
	apbConfig #(
		.ADDR_W       (ADDR_W)
	) apbConfig_i (
		.clk          (clk),
		.i_rstN       (i_rstN),
		.i_psel       (i_psel),
		.i_penable    (i_penable),
		.i_pwrite     (i_pwrite),
		.i_paddr      (i_paddr),
		.i_pwdata     (i_pwdata),
		.o_prdata     (o_prdata),
		.o_pready     (o_pready),
		.o_pslverr    (o_pslverr),
		.i_busy       (idctBusy),
		.o_cfg        (cfg),
		.o_signedOut  (signedOut)
	);

	// Stream to coef positions, stalled by IDCT
	rleDecoder rleDecoder_i (
		.clk          (clk),
		.i_rstN       (i_rstN),
		.i_dataValid  (i_dataValid),
		.i_data       (i_data),
		.o_dataReady  (o_dataReady),
		.i_idctBusy   (idctBusy),
		.o_coef       (rleCoef)
	);

	// Two cycle quant pipe
	dequantizer dequantizer_i (
		.clk          (clk),
		.i_rstN       (i_rstN),
		.i_coef       (rleCoef),
		.i_cfg        (cfg),
		.o_coef       (coefWr)
	);

	idctCore idctCore_i (
		.clk          (clk),
		.i_rstN       (i_rstN),
		.i_coef       (coefWr),
		.i_cfg        (cfg),
		.i_signedOut  (signedOut),
		.o_busy       (idctBusy),
		.o_pixel      (o_pixel)
	);

endmodule

`default_nettype wire

// File: sim/mdecCore_props.sv
`timescale 1ns/1ps
`default_nettype none

module mdecCore_props import mdecPkg::*; (
	input  wire    clk,
	input  wire    i_rstN,
	input  wire    i_psel,
	input  wire    i_pready,
	input  wire    i_pslverr,
	input  wire    i_dataReady,
	input  wire    i_busy,
	input  pixel_t i_pixel
);

	// Read by the testbench at the end of the run
	int failCount = 0;

	// ----------------------------------------
	// Handshake rules
	// ----------------------------------------
	// Stream stalls while the IDCT holds a block
	readyLowWhenBusy: assert property (@(posedge clk) disable iff (!i_rstN)
		i_busy |-> !i_dataReady)
	else
	begin
		failCount++;
		$error("Stream ready high while IDCT busy");
	end

	// No wait states on APB
	readyWithSelect: assert property (@(posedge clk) disable iff (!i_rstN)
		i_psel |-> i_pready)
	else
	begin
		failCount++;
		$error("PREADY low during a selected APB cycle");
	end

	// Idle outputs one cycle after reset
	resetValues: assert property (@(posedge clk)
		!i_rstN |=> (!i_busy && !i_pixel.valid && i_dataReady && !i_pslverr))
	else
	begin
		failCount++;
		$error("Outputs not idle after reset");
	end

	// ----------------------------------------
	// Pixel raster order
	// ----------------------------------------
	pixelFirstAddr: assert property (@(posedge clk) disable iff (!i_rstN)
		$rose(i_pixel.valid) |-> (i_pixel.addr == 6'd0))
	else
	begin
		failCount++;
		$error("Block output did not start at address 0");
	end

	// Consecutive addresses up to 63
	pixelAddrStep: assert property (@(posedge clk) disable iff (!i_rstN)
		(i_pixel.valid && (i_pixel.addr != 6'd63))
		|=> (i_pixel.valid && (i_pixel.addr == $past(i_pixel.addr) + 6'd1)))
	else
	begin
		failCount++;
		$error("Pixel address did not step by one");
	end

endmodule

`default_nettype wire

// File: sim/mdecCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mdecCore_tb import mdecPkg::*; #(
	parameter int SEED = 32'h78a1
);

	localparam int ADDR_W = 12;
	localparam int CLK_PERIOD = 20;
	localparam logic [15:0] EOB = 16'hFE00;
	// Watchdog budget, blocks plus table loads
	localparam int NUM_BLOCKS = 12;
	localparam int BLOCK_CYCLES = 2000;
	localparam int APB_CYCLES = 2048;
	localparam int TIMEOUT_CYCLES = NUM_BLOCKS * BLOCK_CYCLES + APB_CYCLES;

	logic        clk;
	logic        rstN;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        dataValid;
	logic [15:0] data;
	logic        dataReady;
	logic        busy;
	pixel_t      pixel;

	int          seed;
	int          errors;
	int          checks;
	int          errBase;
	int          chkBase;
	int          signedMode;
	int          quantTbl [64];
	int          cosTbl [64];
	int          zz [64];
	logic [15:0] blk [$];
	logic [15:0] stream [$];
	logic [7:0]  expQ [$];
	pixel_t      pixQ [$];

	mdecCore #(
		.ADDR_W      (ADDR_W)
	) mdecCore_i (
		.clk         (clk),
		.i_rstN      (rstN),
		.i_psel      (psel),
		.i_penable   (penable),
		.i_pwrite    (pwrite),
		.i_paddr     (paddr),
		.i_pwdata    (pwdata),
		.o_prdata    (prdata),
		.o_pready    (pready),
		.o_pslverr   (pslverr),
		.i_dataValid (dataValid),
		.i_data      (data),
		.o_dataReady (dataReady),
		.o_busy      (busy),
		.o_pixel     (pixel)
	);

	bind mdecCore mdecCore_props props_i (
		.clk         (clk),
		.i_rstN      (i_rstN),
		.i_psel      (i_psel),
		.i_pready    (o_pready),
		.i_pslverr   (o_pslverr),
		.i_dataReady (o_dataReady),
		.i_busy      (o_busy),
		.i_pixel     (o_pixel)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Pixels sampled mid cycle
	always @(negedge clk)
	begin
		if (rstN && pixel.valid)
			pixQ.push_back(pixel);
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, a block never finished", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	// ----------------------------------------
	// Checking and reporting
	// ----------------------------------------
	task automatic checkEqual(input string name, input string what, input int expVal,
		input int actVal);
		checks++;
		assert (expVal == actVal)
		else
		begin
			errors++;
			$display("Mismatch %s %s: expected %0d, actual %0d", name, what, expVal, actVal);
		end
	endtask

	task automatic beginTest();
		errBase = errors;
		chkBase = checks;
	endtask

	task automatic endTest(input string name);
		$display("Test %-12s %0d checks, %0d errors", name, checks - chkBase, errors - errBase);
	endtask

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	// Zigzag walk over the anti-diagonals
	function automatic void buildZigzag();
		int n;
		int row;
		n = 0;
		for (int s = 0; s < 15; s++)
		begin
			// Even diagonals climb, odd ones descend
			for (int k = 0; k < 8; k++)
			begin
				row = (s % 2 == 0) ? 7 - k : k;
				if ((row <= s) && (s - row < 8))
				begin
					zz[n] = row * 8 + (s - row);
					n++;
				end
			end
		end
	endfunction

	function automatic int saturate(input longint v);
		if (v > 2047)
			return 2047;
		if (v < -2047)
			return -2047;
		return int'(v);
	endfunction

	// Decodes blk and queues its 64 expected pixels
	function automatic void predictBlock();
		longint coef [64];
		longint tmp [64];
		longint acc;
		int pos;
		int level;
		int scale;
		for (int i = 0; i < 64; i++)
			coef[i] = 0;
		scale = int'(blk[0][15:10]);
		level = int'($signed(blk[0][9:0]));
		coef[0] = saturate(longint'(level) * quantTbl[0]);
		pos = 0;
		for (int i = 1; i < blk.size(); i++)
		begin
			if (blk[i] == EOB)
				break;
			pos = pos + int'(blk[i][15:10]) + 1;
			if (pos > 63)
				break;
			level = int'($signed(blk[i][9:0]));
			coef[zz[pos]] = saturate((longint'(level) * quantTbl[pos] * scale) >>> 3);
			if (pos == 63)
				break;
		end
		// Rows first
		for (int u = 0; u < 8; u++)
			for (int x = 0; x < 8; x++)
			begin
				acc = 0;
				for (int v = 0; v < 8; v++)
					acc += cosTbl[v * 8 + x] * coef[u * 8 + v];
				tmp[u * 8 + x] = acc >>> 14;
			end
		// Then columns, raster order out
		for (int y = 0; y < 8; y++)
			for (int x = 0; x < 8; x++)
			begin
				acc = 0;
				for (int u = 0; u < 8; u++)
					acc += cosTbl[u * 8 + y] * tmp[u * 8 + x];
				acc = acc >>> 14;
				if (acc > 127)
					acc = 127;
				else if (acc < -128)
					acc = -128;
				if (signedMode == 0)
					acc += 128;
				expQ.push_back(8'(acc));
			end
	endfunction

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	task automatic apbAccess(input logic write, input logic [11:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		// Transfer completes on the edge after PREADY is seen
		do
		begin
			@(negedge clk);
		end
		while (!pready);
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic setSigned(input int mode);
		logic [31:0] rd;
		logic err;
		apbAccess(1'b1, 12'h000, 32'(mode), rd, err);
		signedMode = mode;
	endtask

	// Fixed quant and cos row 0 = k, or random tables
	task automatic loadTables(input bit randomTbl, input int k, input int quant);
		logic [31:0] rd;
		logic err;
		for (int i = 0; i < 64; i++)
		begin
			if (randomTbl)
			begin
				quantTbl[i] = 1 + int'($unsigned($random(seed)) % 15);
				cosTbl[i]   = $random(seed) % 4096;
			end
			else
			begin
				quantTbl[i] = quant;
				cosTbl[i]   = (i < 8) ? k : 0;
			end
			apbAccess(1'b1, 12'(12'h100 + 4 * i), 32'(quantTbl[i]), rd, err);
			apbAccess(1'b1, 12'(12'h200 + 4 * i), 32'(cosTbl[i]), rd, err);
		end
	endtask

	task automatic startBlock(input int scale, input int dc);
		blk.delete();
		blk.push_back({6'(scale), 10'(dc)});
	endtask

	task automatic addAc(input int run, input int level);
		blk.push_back({6'(run), 10'(level)});
	endtask

	task automatic endBlock(input bit withEob);
		if (withEob)
			blk.push_back(EOB);
		predictBlock();
		foreach (blk[i])
			stream.push_back(blk[i]);
	endtask

	// Random runs and levels, closed by EOB
	task automatic randomBlock();
		int pos;
		int run;
		startBlock(1 + int'($unsigned($random(seed)) % 7), $random(seed) % 64);
		pos = 0;
		run = int'($unsigned($random(seed)) % 6);
		while (pos + run + 1 < 63)
		begin
			addAc(run, $random(seed) % 64);
			pos = pos + run + 1;
			run = int'($unsigned($random(seed)) % 6);
		end
		endBlock(1'b1);
	endtask

	// Valid stays high from first to last queued word
	task automatic sendStream();
		int idx;
		idx = 0;
		@(posedge clk);
		dataValid <= 1'b1;
		data      <= stream[0];
		while (idx < stream.size())
		begin
			// Word moves on the next rising edge if ready now
			@(negedge clk);
			if (dataReady)
				idx++;
			@(posedge clk);
			if (idx < stream.size())
				data <= stream[idx];
			else
				dataValid <= 1'b0;
		end
		stream.delete();
	endtask

	// Counts falling edges of busy
	task automatic waitBlocks(input int count);
		int seen;
		logic prev;
		seen = 0;
		prev = busy;
		while (seen < count)
		begin
			@(negedge clk);
			if (prev && !busy)
				seen++;
			prev = busy;
		end
	endtask

	task automatic checkBlocks(input string name, input int count);
		pixel_t px;
		logic [7:0] expVal;
		for (int b = 0; b < count; b++)
			for (int i = 0; i < 64; i++)
			begin
				expVal = expQ.pop_front();
				assert (pixQ.size() > 0)
				else
				begin
					errors++;
					$display("%s: pixel %0d of block %0d never appeared", name, i, b);
				end
				if (pixQ.size() > 0)
				begin
					px = pixQ.pop_front();
					checkEqual(name, $sformatf("block %0d address", b), i, int'(px.addr));
					checkEqual(name, $sformatf("block %0d pixel %0d", b, i), int'(expVal),
						int'(px.value));
				end
			end
		assert (pixQ.size() == 0)
		else
		begin
			errors++;
			$display("%s: %0d pixels more than expected", name, pixQ.size());
			pixQ.delete();
		end
	endtask

	task automatic runBlocks(input string name, input int count);
		fork
			sendStream();
			waitBlocks(count);
		join
		checkBlocks(name, count);
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial
	begin
		logic [31:0] rd;
		logic err;
		seed       = SEED;
		errors     = 0;
		checks     = 0;
		signedMode = 0;
		rstN       = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		dataValid  = 1'b0;
		data       = '0;
		buildZigzag();
		repeat (16) @(posedge clk);
		rstN <= 1'b1;

		// Control readback, unmapped errors, busy status
		beginTest();
		loadTables(1'b0, 8192, 8);
		apbAccess(1'b1, 12'h000, 32'd1, rd, err);
		apbAccess(1'b0, 12'h000, 32'd0, rd, err);
		checkEqual("apbConfig", "control read", 1, int'(rd[0]));
		checkEqual("apbConfig", "control error", 0, int'(err));
		apbAccess(1'b1, 12'h000, 32'd0, rd, err);
		apbAccess(1'b0, 12'h000, 32'd0, rd, err);
		checkEqual("apbConfig", "control cleared", 0, int'(rd[0]));
		apbAccess(1'b0, 12'h008, 32'd0, rd, err);
		checkEqual("apbConfig", "unmapped read error", 1, int'(err));
		apbAccess(1'b1, 12'h300, 32'd5, rd, err);
		checkEqual("apbConfig", "unmapped write error", 1, int'(err));
		startBlock(0, 20);
		endBlock(1'b1);
		fork
			sendStream();
			waitBlocks(1);
			begin
				do
				begin
					@(negedge clk);
				end
				while (!busy);
				apbAccess(1'b0, 12'h004, 32'd0, rd, err);
				checkEqual("apbConfig", "status busy", 1, int'(rd[0]));
			end
		join
		apbAccess(1'b0, 12'h004, 32'd0, rd, err);
		checkEqual("apbConfig", "status idle", 0, int'(rd[0]));
		checkBlocks("apbConfig", 1);
		endTest("apbConfig");

		// Only DC and cos row 0, flat block
		beginTest();
		startBlock(3, 40);
		endBlock(1'b1);
		runBlocks("dcOnly", 1);
		endTest("dcOnly");

		beginTest();
		loadTables(1'b1, 0, 0);
		randomBlock();
		runBlocks("randomBlock", 1);
		endTest("randomBlock");

		// Run lands on 63, next block sparse
		beginTest();
		startBlock(5, -30);
		addAc(10, 25);
		addAc(51, -17);
		endBlock(1'b0);
		runBlocks("implicitEnd", 1);
		startBlock(2, 12);
		addAc(1, 9);
		endBlock(1'b1);
		runBlocks("implicitEnd", 1);
		endTest("implicitEnd");

		beginTest();
		randomBlock();
		randomBlock();
		runBlocks("backPressure", 2);
		endTest("backPressure");

		// Unit gain, DC saturates both ways
		beginTest();
		loadTables(1'b0, 16384, 8);
		for (int mode = 1; mode >= 0; mode--)
		begin
			setSigned(mode);
			startBlock(0, 511);
			endBlock(1'b1);
			startBlock(0, -512);
			endBlock(1'b1);
			runBlocks("clamping", 2);
		end
		endTest("clamping");

		errors += mdecCore_i.props_i.failCount;
		$display("Tests: 6, checks: %0d, errors: %0d, property failures: %0d", checks, errors,
			mdecCore_i.props_i.failCount);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: mdec.f
logic/mdecPkg.sv
logic/apbConfig.sv
logic/rleDecoder.sv
logic/dequantizer.sv
logic/idctCore.sv
logic/mdecCore.sv
sim/mdecCore_props.sv
sim/mdecCore_tb.sv

// File: Makefile
# Verilator build and run for the MDEC core testbench

VERILATOR ?= verilator
TOP       ?= mdecCore_tb
FILELIST  ?= mdec.f
LOG       ?= sim.log
SEED      ?= 30881
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST LOG SEED OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
